/* hdl/host_stream_pkg.sv */
`default_nettype none

package host_stream_pkg;

  // --------------------
  // Host and region data streams
  // --------------------

  // Width of tdata on every region stream and on the host stream
  localparam int data_bits = 64;

  // One keep bit per data byte
  localparam int keep_bits = data_bits / 8;

  // --------------------
  // Virtual regions
  // --------------------

  // Number of regions sharing the host stream
  localparam int n_regions = 4;

  // Region id width
  // Sized so that ids wrap at n_regions
  localparam int region_bits = 2;

endpackage

`default_nettype wire

/* hdl/host_req_pkg.sv */
`default_nettype none

package host_req_pkg;

  // --------------------
  // Write request format
  // --------------------

  // Beat count field, holds beats minus one
  // So one burst covers 1 to 64 beats
  localparam int len_bits = 6;

  // --------------------
  // Request queue sizing
  // --------------------

  // Entries per region queue
  localparam int queue_depth = 4;

  // Read and write pointer width, wraps at queue_depth
  localparam int queue_ptr_bits = 2;

  // Mux FSM states
  typedef enum logic [0:0] {
    mux_idle,
    mux_pass
  } mux_state_t;

endpackage

`default_nettype wire

/* hdl/req_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module req_queue (
  input  logic                              aclk,
  input  logic                              aresetn,

  // Requests from one region
  input  logic                              in_valid,
  output logic                              in_ready,
  input  logic [host_req_pkg::len_bits-1:0] in_len,
  input  logic                              in_last,

  // Oldest pending request, towards the arbiter
  output logic                              out_valid,
  input  logic                              out_ready,
  output logic [host_req_pkg::len_bits-1:0] out_len,
  output logic                              out_last
);

  // Entry storage
  logic [host_req_pkg::len_bits-1:0]       len_mem  [host_req_pkg::queue_depth];
  logic                                    last_mem [host_req_pkg::queue_depth];

  // Pointers and occupancy
  logic [host_req_pkg::queue_ptr_bits-1:0] wr_ptr;
  logic [host_req_pkg::queue_ptr_bits-1:0] rd_ptr;
  logic [host_req_pkg::queue_ptr_bits:0]   fill_cnt;

  logic                                    push;
  logic                                    pop;

  // Full only when every entry holds a request
  assign in_ready  = (fill_cnt !=
                      (host_req_pkg::queue_ptr_bits + 1)'(host_req_pkg::queue_depth));
  assign out_valid = (fill_cnt != '0);

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Head entry read straight from storage
  assign out_len  = len_mem[rd_ptr];
  assign out_last = last_mem[rd_ptr];

  // Payload write
  always_ff @(posedge aclk) begin
    if (push) begin
      len_mem[wr_ptr]  <= in_len;
      last_mem[wr_ptr] <= in_last;
    end
  end

  // Pointer and count update
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill_cnt <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/req_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module req_arbiter (
  input  logic                                                      aclk,
  input  logic                                                      aresetn,

  // Region queue heads
  input  logic [host_stream_pkg::n_regions-1:0]                     q_valid,
  output logic [host_stream_pkg::n_regions-1:0]                     q_ready,
  input  logic [host_stream_pkg::n_regions-1:0][host_req_pkg::len_bits-1:0] q_len,
  input  logic [host_stream_pkg::n_regions-1:0]                     q_last,

  // Registered mux command
  output logic                                                      cmd_valid,
  input  logic                                                      cmd_ready,
  output logic [host_stream_pkg::region_bits-1:0]                   cmd_region,
  output logic [host_req_pkg::len_bits-1:0]                         cmd_len,
  output logic                                                      cmd_last
);

  // Last region granted
  logic [host_stream_pkg::region_bits-1:0] grant_ptr;

  // Search results
  logic [host_stream_pkg::region_bits-1:0] cand;
  logic [host_stream_pkg::region_bits-1:0] pick;
  logic                                    found;

  // Command register free now or freed this cycle
  logic                                    load_en;

  assign load_en = !cmd_valid || cmd_ready;

  // --------------------
  // Round-robin search
  // --------------------
  // Starts one past the last grant, so the last grant is checked last
  always_comb begin
    found = 1'b0;
    pick  = grant_ptr;
    cand  = grant_ptr;
    for (int i = 1; i <= host_stream_pkg::n_regions; i++) begin
      // Id wraps at n_regions
      cand = grant_ptr + (host_stream_pkg::region_bits)'(i);
      if (!found && q_valid[cand]) begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  // Pop only the chosen queue
  always_comb begin
    for (int k = 0; k < host_stream_pkg::n_regions; k++) begin
      q_ready[k] = load_en && found && (pick == (host_stream_pkg::region_bits)'(k));
    end
  end

  // --------------------
  // Command register
  // --------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cmd_valid <= 1'b0;
      // First search after reset begins at region 0
      grant_ptr <= (host_stream_pkg::region_bits)'(host_stream_pkg::n_regions - 1);
    end else if (load_en) begin
      cmd_valid <= found;
      if (found) grant_ptr <= pick;
    end
  end

  // Command fields
  always_ff @(posedge aclk) begin
    if (load_en && found) begin
      cmd_region <= pick;
      cmd_len    <= q_len[pick];
      cmd_last   <= q_last[pick];
    end
  end

endmodule

`default_nettype wire

/* hdl/axis_host_sink_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module axis_host_sink_mux (
  input  logic                                   aclk,
  input  logic                                   aresetn,

  // Burst command from the arbiter
  input  logic                                   cmd_valid,
  output logic                                   cmd_ready,
  input  logic [host_stream_pkg::region_bits-1:0] cmd_region,
  input  logic [host_req_pkg::len_bits-1:0]      cmd_len,
  input  logic                                   cmd_last,

  // Region data streams
  input  logic [host_stream_pkg::n_regions-1:0]  s_tvalid,
  output logic [host_stream_pkg::n_regions-1:0]  s_tready,
  input  logic [host_stream_pkg::n_regions-1:0][host_stream_pkg::data_bits-1:0] s_tdata,
  input  logic [host_stream_pkg::n_regions-1:0][host_stream_pkg::keep_bits-1:0] s_tkeep,
  input  logic [host_stream_pkg::n_regions-1:0]  s_tlast,

  // Host stream
  output logic                                   m_tvalid,
  input  logic                                   m_tready,
  output logic [host_stream_pkg::data_bits-1:0]  m_tdata,
  output logic [host_stream_pkg::keep_bits-1:0]  m_tkeep,
  output logic                                   m_tlast
);

  // FSM
  host_req_pkg::mux_state_t state_q;
  host_req_pkg::mux_state_t state_d;

  // Current burst
  logic [host_stream_pkg::region_bits-1:0] region_q;
  logic [host_stream_pkg::region_bits-1:0] region_d;
  logic [host_req_pkg::len_bits-1:0]       cnt_q;
  logic [host_req_pkg::len_bits-1:0]       cnt_d;
  logic                                    last_q;
  logic                                    last_d;

  // Handshake helpers
  logic                                    beat;
  logic                                    tr_done;
  logic                                    take;

  // --------------------
  // Stream steering
  // --------------------
  always_comb begin
    // Only the selected region sees ready
    for (int i = 0; i < host_stream_pkg::n_regions; i++) begin
      if (state_q == host_req_pkg::mux_pass &&
          region_q == (host_stream_pkg::region_bits)'(i)) begin
        s_tready[i] = m_tready;
      end else begin
        s_tready[i] = 1'b0;
      end
    end

    if (state_q == host_req_pkg::mux_pass) begin
      m_tvalid = s_tvalid[region_q];
      m_tdata  = s_tdata[region_q];
      m_tkeep  = s_tkeep[region_q];
      // Packet end only when the command closes the packet
      m_tlast  = s_tlast[region_q] && last_q;
    end else begin
      m_tvalid = 1'b0;
      m_tdata  = '0;
      m_tkeep  = '0;
      m_tlast  = 1'b0;
    end
  end

  // Host transfer, and final beat of the burst
  assign beat    = m_tvalid && m_tready;
  assign tr_done = beat && (cnt_q == '0);

  // Next command taken when idle or on the last beat
  assign cmd_ready = (state_q == host_req_pkg::mux_idle) || tr_done;
  assign take      = cmd_valid && cmd_ready;

  // --------------------
  // Next state and datapath
  // --------------------
  always_comb begin
    state_d  = state_q;
    region_d = region_q;
    cnt_d    = cnt_q;
    last_d   = last_q;

    case (state_q)
      host_req_pkg::mux_idle: begin
        if (cmd_valid) state_d = host_req_pkg::mux_pass;
      end
      host_req_pkg::mux_pass: begin
        if (tr_done && !cmd_valid) begin
          state_d = host_req_pkg::mux_idle;
        end else if (beat && !tr_done) begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      default: state_d = host_req_pkg::mux_idle;
    endcase

    // Load new burst, back to back on tr_done
    if (take) begin
      region_d = cmd_region;
      cnt_d    = cmd_len;
      last_d   = cmd_last;
    end
  end

  // State register
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= host_req_pkg::mux_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Burst registers
  always_ff @(posedge aclk) begin
    region_q <= region_d;
    cnt_q    <= cnt_d;
    last_q   <= last_d;
  end

endmodule

`default_nettype wire

/* hdl/host_sink_top.sv */
`timescale 1ns/100ps
`default_nettype none

module host_sink_top (
  input  logic                                   aclk,
  input  logic                                   aresetn,

  // Write requests, one lane per region
  input  logic [host_stream_pkg::n_regions-1:0]  req_valid,
  output logic [host_stream_pkg::n_regions-1:0]  req_ready,
  input  logic [host_stream_pkg::n_regions-1:0][host_req_pkg::len_bits-1:0] req_len,
  input  logic [host_stream_pkg::n_regions-1:0]  req_last,

  // Region data streams
  input  logic [host_stream_pkg::n_regions-1:0]  s_tvalid,
  output logic [host_stream_pkg::n_regions-1:0]  s_tready,
  input  logic [host_stream_pkg::n_regions-1:0][host_stream_pkg::data_bits-1:0] s_tdata,
  input  logic [host_stream_pkg::n_regions-1:0][host_stream_pkg::keep_bits-1:0] s_tkeep,
  input  logic [host_stream_pkg::n_regions-1:0]  s_tlast,

  // Host stream
  output logic                                   m_tvalid,
  input  logic                                   m_tready,
  output logic [host_stream_pkg::data_bits-1:0]  m_tdata,
  output logic [host_stream_pkg::keep_bits-1:0]  m_tkeep,
  output logic                                   m_tlast
);

  // Queue heads towards the arbiter
  logic [host_stream_pkg::n_regions-1:0]                           q_valid;
  logic [host_stream_pkg::n_regions-1:0]                           q_ready;
  logic [host_stream_pkg::n_regions-1:0][host_req_pkg::len_bits-1:0] q_len;
  logic [host_stream_pkg::n_regions-1:0]                           q_last;

  // Arbiter to mux command
  logic                                    cmd_valid;
  logic                                    cmd_ready;
  logic [host_stream_pkg::region_bits-1:0] cmd_region;
  logic [host_req_pkg::len_bits-1:0]       cmd_len;
  logic                                    cmd_last;

  // --------------------
  // Per-region request queues
  // --------------------
  for (genvar r = 0; r < host_stream_pkg::n_regions; r++) begin : g_queue
    req_queue u_queue (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_valid  (req_valid[r]),
      .in_ready  (req_ready[r]),
      .in_len    (req_len[r]),
      .in_last   (req_last[r]),
      .out_valid (q_valid[r]),
      .out_ready (q_ready[r]),
      .out_len   (q_len[r]),
      .out_last  (q_last[r])
    );
  end

  // Round-robin command source
  req_arbiter u_arbiter (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .q_valid    (q_valid),
    .q_ready    (q_ready),
    .q_len      (q_len),
    .q_last     (q_last),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_region (cmd_region),
    .cmd_len    (cmd_len),
    .cmd_last   (cmd_last)
  );

  // Stream mux onto the host
  axis_host_sink_mux u_mux (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_region (cmd_region),
    .cmd_len    (cmd_len),
    .cmd_last   (cmd_last),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .s_tdata    (s_tdata),
    .s_tkeep    (s_tkeep),
    .s_tlast    (s_tlast),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_tdata    (m_tdata),
    .m_tkeep    (m_tkeep),
    .m_tlast    (m_tlast)
  );

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic aclk,
  output logic aresetn
);

  // 40 ns period
  localparam real half_period = 20.0;

  initial begin
    aclk = 1'b0;
    forever #(half_period) aclk = ~aclk;
  end

  // Reset held over 8 rising edges, released just after the last one
  initial begin
    aresetn = 1'b0;
    repeat (8) @(posedge aclk);
    #2 aresetn = 1'b1;
  end

endmodule

`default_nettype wire

/* test/tb_host_sink.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_host_sink;

  // --------------------
  // Test sizing
  // --------------------
  // First rr_reqs of each region go in together for the round-robin phase
  localparam int reqs_per_region = 10;
  localparam int rr_reqs         = 3;
  localparam int rr_bursts       = rr_reqs * host_stream_pkg::n_regions;
  localparam int max_beats       = reqs_per_region * 64;

  logic aclk;
  logic aresetn;

  // DUT inputs
  logic [host_stream_pkg::n_regions-1:0]                              req_valid;
  logic [host_stream_pkg::n_regions-1:0][host_req_pkg::len_bits-1:0]   req_len;
  logic [host_stream_pkg::n_regions-1:0]                              req_last;
  logic [host_stream_pkg::n_regions-1:0]                              s_tvalid;
  logic [host_stream_pkg::n_regions-1:0][host_stream_pkg::data_bits-1:0] s_tdata;
  logic [host_stream_pkg::n_regions-1:0][host_stream_pkg::keep_bits-1:0] s_tkeep;
  logic [host_stream_pkg::n_regions-1:0]                              s_tlast;
  logic                                                               m_tready;

  // DUT outputs
  logic [host_stream_pkg::n_regions-1:0] req_ready;
  logic [host_stream_pkg::n_regions-1:0] s_tready;
  logic                                  m_tvalid;
  logic [host_stream_pkg::data_bits-1:0] m_tdata;
  logic [host_stream_pkg::keep_bits-1:0] m_tkeep;
  logic                                  m_tlast;

  // --------------------
  // Region models
  // --------------------
  logic [host_req_pkg::len_bits-1:0]     req_len_tab  [host_stream_pkg::n_regions][reqs_per_region];
  logic                                  req_last_tab [host_stream_pkg::n_regions][reqs_per_region];
  logic [host_stream_pkg::data_bits-1:0] beat_data    [host_stream_pkg::n_regions][max_beats];
  logic [host_stream_pkg::keep_bits-1:0] beat_keep    [host_stream_pkg::n_regions][max_beats];
  // Final beat of its burst, and last flag of its request
  logic                                  beat_final   [host_stream_pkg::n_regions][max_beats];
  logic                                  beat_plast   [host_stream_pkg::n_regions][max_beats];
  int                                    n_beats      [host_stream_pkg::n_regions];
  int                                    req_idx      [host_stream_pkg::n_regions];
  int                                    drv_idx      [host_stream_pkg::n_regions];
  int                                    chk_idx      [host_stream_pkg::n_regions];

  // Handshakes seen at the last falling edge
  logic [host_stream_pkg::n_regions-1:0] req_fire;
  logic [host_stream_pkg::n_regions-1:0] dat_fire;

  // Host side tracking
  logic                                    in_burst;
  logic [host_stream_pkg::region_bits-1:0] cur_region;
  int                                      bursts_seen;
  int                                      checked_beats;
  int                                      total_beats;

  int   ready_hold;
  int   seed;
  int   timeout_cycles = 0;
  int   cycle_cnt = 0;
  logic failed;

  tb_clock_gen u_clock (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  host_sink_top DUT (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_len   (req_len),
    .req_last  (req_last),
    .s_tvalid  (s_tvalid),
    .s_tready  (s_tready),
    .s_tdata   (s_tdata),
    .s_tkeep   (s_tkeep),
    .s_tlast   (s_tlast),
    .m_tvalid  (m_tvalid),
    .m_tready  (m_tready),
    .m_tdata   (m_tdata),
    .m_tkeep   (m_tkeep),
    .m_tlast   (m_tlast)
  );

  // --------------------
  // Failure reporting
  // --------------------
  task automatic end_in_failure();
    $display("** FAIL **");
    $fatal(1, "Run stopped on the first error");
  endtask

  task automatic report_mismatch(input string test, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    failed = 1'b1;
    $display("** Error %s: expected %0h, actual %0h", test, exp_val, act_val);
    end_in_failure();
  endtask

  task automatic fail_with_reason(input string reason);
    failed = 1'b1;
    $display("%s", reason);
    end_in_failure();
  endtask

  // Requests and beats of one region
  // Word holds the region tag, random middle bits and the sequence number
  task automatic build_region_model(input int r);
    int seq;
    int len;
    logic [host_stream_pkg::data_bits-1:0] word;
    seq = 0;
    for (int i = 0; i < reqs_per_region; i++) begin
      len = $random(seed) & 63;
      req_len_tab[r][i]  = (host_req_pkg::len_bits)'(len);
      req_last_tab[r][i] = (($random(seed) & 1) == 1);
      for (int b = 0; b <= len; b++) begin
        word = {$random(seed), $random(seed)};
        word[host_stream_pkg::data_bits-1 -: host_stream_pkg::region_bits] =
          (host_stream_pkg::region_bits)'(r);
        word[31:0] = 32'(seq);
        beat_data[r][seq]  = word;
        beat_keep[r][seq]  = (host_stream_pkg::keep_bits)'($random(seed));
        beat_final[r][seq] = (b == len);
        beat_plast[r][seq] = req_last_tab[r][i];
        seq++;
      end
    end
    n_beats[r] = seq;
  endtask

  // --------------------
  // Stimulus
  // --------------------
  task automatic issue_requests();
    logic may_issue;
    for (int r = 0; r < host_stream_pkg::n_regions; r++) begin
      if (req_fire[r]) begin
        req_valid[r] = 1'b0;
        req_idx[r]++;
      end
      if (!req_valid[r] && req_idx[r] < reqs_per_region) begin
        // Round-robin requests go back to back
        // Later ones wait for the round-robin bursts
        if (req_idx[r] < rr_reqs) begin
          may_issue = 1'b1;
        end else begin
          may_issue = (bursts_seen >= rr_bursts) && (($random(seed) & 3) == 0);
        end
        if (may_issue) begin
          req_valid[r] = 1'b1;
          req_len[r]   = req_len_tab[r][req_idx[r]];
          req_last[r]  = req_last_tab[r][req_idx[r]];
        end
      end
    end
  endtask

  task automatic present_region_beats();
    logic rr_loaded;
    rr_loaded = 1'b1;
    for (int r = 0; r < host_stream_pkg::n_regions; r++) begin
      if (req_idx[r] < rr_reqs) rr_loaded = 1'b0;
    end
    for (int r = 0; r < host_stream_pkg::n_regions; r++) begin
      if (dat_fire[r]) begin
        s_tvalid[r] = 1'b0;
        drv_idx[r]++;
      end
      // No data until all round-robin requests are queued
      if (!s_tvalid[r] && rr_loaded && drv_idx[r] < n_beats[r] &&
          (($random(seed) & 3) != 0)) begin
        s_tvalid[r] = 1'b1;
        s_tdata[r]  = beat_data[r][drv_idx[r]];
        s_tkeep[r]  = beat_keep[r][drv_idx[r]];
        s_tlast[r]  = beat_final[r][drv_idx[r]];
      end
    end
  endtask

  // Host ready held in stretches of 1 to 8 cycles
  // Mostly high
  task automatic toggle_host_ready();
    if (ready_hold == 0) begin
      m_tready   = (($random(seed) & 3) != 0);
      ready_hold = 1 + ($random(seed) & 7);
    end
    ready_hold--;
  endtask

  // --------------------
  // Checks
  // --------------------
  task automatic verify_reset_state();
    assert (m_tvalid === 1'b0)
      else report_mismatch("reset_m_tvalid", 64'(0), 64'(m_tvalid));
    assert (s_tready === '0)
      else report_mismatch("reset_s_tready", 64'(0), 64'(s_tready));
    assert (req_ready === '1)
      else report_mismatch("reset_req_ready", 64'((1 << host_stream_pkg::n_regions) - 1),
                           64'(req_ready));
  endtask

  task automatic check_host_beat();
    logic [host_stream_pkg::region_bits-1:0] tag;
    logic [host_stream_pkg::n_regions-1:0]   exp_ready;
    logic exp_last;
    int   i;
    tag = m_tdata[host_stream_pkg::data_bits-1 -: host_stream_pkg::region_bits];
    if (!in_burst) begin
      in_burst   = 1'b1;
      cur_region = tag;
      // Bursts of the round-robin phase
      if (bursts_seen < rr_bursts) begin
        assert (int'(tag) == bursts_seen % host_stream_pkg::n_regions)
          else report_mismatch("round_robin", 64'(bursts_seen % host_stream_pkg::n_regions),
                               64'(tag));
      end
    end
    assert (tag == cur_region)
      else report_mismatch("burst_integrity", 64'(cur_region), 64'(tag));
    // Only the region of the burst sees ready
    exp_ready = (host_stream_pkg::n_regions)'(1) << cur_region;
    assert (s_tready == exp_ready)
      else report_mismatch("ready_select", 64'(exp_ready), 64'(s_tready));
    i = chk_idx[tag];
    assert (i < n_beats[tag])
      else report_mismatch("beat_count", 64'(n_beats[tag]), 64'(i + 1));
    assert (m_tdata == beat_data[tag][i])
      else report_mismatch("data_order", beat_data[tag][i], m_tdata);
    assert (m_tkeep == beat_keep[tag][i])
      else report_mismatch("keep", 64'(beat_keep[tag][i]), 64'(m_tkeep));
    // Packet end only on a closing burst's final beat
    exp_last = beat_final[tag][i] && beat_plast[tag][i];
    assert (m_tlast == exp_last)
      else report_mismatch("tlast_rule", 64'(exp_last), 64'(m_tlast));
    chk_idx[tag]++;
    checked_beats++;
    if (beat_final[tag][i]) begin
      in_burst = 1'b0;
      bursts_seen++;
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    seed          = 23449;
    failed        = 1'b0;
    req_valid     = '0;
    req_len       = '0;
    req_last      = '0;
    s_tvalid      = '0;
    s_tdata       = '0;
    s_tkeep       = '0;
    s_tlast       = '0;
    m_tready      = 1'b0;
    req_fire      = '0;
    dat_fire      = '0;
    in_burst      = 1'b0;
    cur_region    = '0;
    bursts_seen   = 0;
    checked_beats = 0;
    total_beats   = 0;
    ready_hold    = 0;
    for (int r = 0; r < host_stream_pkg::n_regions; r++) begin
      build_region_model(r);
      req_idx[r]  = 0;
      drv_idx[r]  = 0;
      chk_idx[r]  = 0;
      total_beats += n_beats[r];
    end
    timeout_cycles = 4 * total_beats + 200;

    // Outputs during reset and on the first falling edge after it
    @(negedge aclk);
    while (aresetn !== 1'b1) begin
      verify_reset_state();
      @(negedge aclk);
    end
    verify_reset_state();

    // Drive after the rising edge, sample at the falling edge
    while (checked_beats < total_beats) begin
      @(posedge aclk);
      #2;
      issue_requests();
      present_region_beats();
      toggle_host_ready();
      @(negedge aclk);
      req_fire = req_valid & req_ready;
      dat_fire = s_tvalid & s_tready;
      if (m_tvalid && m_tready) check_host_beat();
    end

    // Nothing extra once every burst is through
    // The last region still offers its final word
    repeat (10) begin
      @(negedge aclk);
      assert (!m_tvalid)
        else fail_with_reason("Host stream carried a beat after all bursts were done");
      assert (s_tready === '0)
        else report_mismatch("drain_s_tready", 64'(0), 64'(s_tready));
    end

    if (!failed) begin
      $display("** PASS **");
      $finish;
    end else begin
      end_in_failure();
    end
  end

  // Run limit from the modelled beat count
  always @(posedge aclk) begin
    if (aresetn === 1'b1) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= timeout_cycles) begin
        $display("Timeout: only %0d of %0d beats reached the host after %0d cycles",
                 checked_beats, total_beats, cycle_cnt);
        end_in_failure();
      end
    end
  end

endmodule

`default_nettype wire

/* flist.f */
hdl/host_stream_pkg.sv
hdl/host_req_pkg.sv
hdl/req_queue.sv
hdl/req_arbiter.sv
hdl/axis_host_sink_mux.sv
hdl/host_sink_top.sv
test/tb_clock_gen.sv
test/tb_host_sink.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the host sink testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_host_sink -f flist.f \
  --Mdir "$build_dir" -o tb_host_sink
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/tb_host_sink" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -qF '** FAIL **' "$log_file"; then
  echo "Simulation failed, see $log_file"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
